/* llc_pkg.sv */
// Widths, address field layout and enums shared by the LLC controller RTL and its testbench
package llc_pkg;

    // ------------------------------------------------
    // Word and pin widths
    // ------------------------------------------------
    localparam int PADDR_BITS     = 16;  // Word address from the higher-level cache
    localparam int DATA_BITS      = 64;  // One word per line
    localparam int DRAM_ADDR_BITS = 17;  // DIMM A[16:0]

    // Address fields, lowest first
    localparam int COL_BITS = 4;
    localparam int BA_BITS  = 2;   // 4 banks per group
    localparam int BG_BITS  = 2;   // 4 bank groups
    localparam int ROW_BITS = 8;

    localparam int COL_LSB = 0;
    localparam int BA_LSB  = COL_LSB + COL_BITS;
    localparam int BG_LSB  = BA_LSB + BA_BITS;
    localparam int ROW_LSB = BG_LSB + BG_BITS;  // Row takes the top of the address

    // Command strobes on the address pins when act_n is high
    localparam int RAS_BIT = 16;
    localparam int CAS_BIT = 15;
    localparam int WE_BIT  = 14;

    // ------------------------------------------------
    // Controller states
    // ------------------------------------------------
    typedef enum logic [3:0] {
        IDLE,        // Ready for a request
        CHECK_HIT,   // Tag compare on the captured address
        ROW_OPEN,    // ACTIVATE on the pins
        ROW_WAIT,
        COL_READ,    // READ on the pins
        READ_WAIT,   // Data lands at the end of this wait
        COL_WRITE,   // WRITE on the pins, write data valid
        WRITE_WAIT,
        CLOSE_ROW,   // PRECHARGE on the pins
        CLOSE_WAIT,
        RESPOND      // Response held until accepted
    } llc_state_t;

    // DIMM command opcodes
    typedef enum logic [2:0] {
        READ      = 3'b000,
        WRITE     = 3'b001,
        ACTIVATE  = 3'b010,
        PRECHARGE = 3'b011,
        NOP       = 3'b111   // Deselect, cs_n stays high
    } dram_cmd_t;

endpackage : llc_pkg

/* llc_line_store.sv */
// Direct-mapped line array for the LLC; combinational hit check and a single fill/update port
module llc_line_store
    import llc_pkg::*;
#(
    parameter int INDEX_BITS = 6  // log2 of the line count
) (
    input  logic                  clk_in,
    input  logic                  rst_N_in,
    input  logic [PADDR_BITS-1:0] lookup_addr,  // Address for both lookup and write
    input  logic                  store_we,     // Fill or update at this edge
    input  logic [DATA_BITS-1:0]  store_data,
    output logic                  hit,
    output logic [DATA_BITS-1:0]  line_data
);

    localparam int LINES    = 1 << INDEX_BITS;
    localparam int TAG_BITS = PADDR_BITS - INDEX_BITS;

    // ------------------------------------------------
    // Storage
    // ------------------------------------------------
    logic [LINES-1:0]     valid_r;            // Cleared by reset
    logic [TAG_BITS-1:0]  tag_r  [LINES];
    logic [DATA_BITS-1:0] data_r [LINES];

    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   tag;

    // Index in the low bits, tag above it
    assign index = lookup_addr[INDEX_BITS-1:0];
    assign tag   = lookup_addr[PADDR_BITS-1:INDEX_BITS];

    // ------------------------------------------------
    // Lookup
    // ------------------------------------------------
    assign hit       = valid_r[index] && (tag_r[index] == tag);
    assign line_data = data_r[index];  // Meaningful only with hit, or after a fill

    // Valid bits
    always_ff @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            valid_r <= '0;  // Cold cache
        end else if (store_we) begin
            valid_r[index] <= 1'b1;
        end
    end

    // Tag and data words
    always_ff @(posedge clk_in) begin
        if (store_we) begin
            tag_r[index]  <= tag;         // Same on a write hit, new on a fill
            data_r[index] <= store_data;
        end
    end

endmodule : llc_line_store

/* dram_cmd_encoder.sv */
// Splits the request word address into DIMM fields and drives the current command onto the pins
module dram_cmd_encoder
    import llc_pkg::*;
(
    input  dram_cmd_t                 dram_cmd,
    input  logic [PADDR_BITS-1:0]     req_addr,
    output logic                      cs_n_out,
    output logic                      act_n_out,
    output logic [DRAM_ADDR_BITS-1:0] dram_addr_out,
    output logic [BG_BITS-1:0]        bg_out,
    output logic [BA_BITS-1:0]        ba_out
);

    logic [COL_BITS-1:0] col;
    logic [ROW_BITS-1:0] row;
    logic                ras;
    logic                cas;
    logic                we;

    // ------------------------------------------------
    // Address split, column lowest and row on top
    // ------------------------------------------------
    assign col    = req_addr[COL_LSB +: COL_BITS];
    assign ba_out = req_addr[BA_LSB +: BA_BITS];
    assign bg_out = req_addr[BG_LSB +: BG_BITS];
    assign row    = req_addr[ROW_LSB +: ROW_BITS];

    assign cs_n_out = (dram_cmd == NOP);  // Selected for every real command

    // RAS/CAS/WE strobes
    always_comb begin
        case (dram_cmd)
            READ:      {ras, cas, we} = 3'b101;
            WRITE:     {ras, cas, we} = 3'b100;
            PRECHARGE: {ras, cas, we} = 3'b010;
            default:   {ras, cas, we} = 3'b111;  // NOP, and unused under ACTIVATE
        endcase
    end

    // Pin forms
    always_comb begin
        dram_addr_out = '0;  // Unused bits low
        if (dram_cmd == ACTIVATE) begin
            act_n_out = 1'b0;
            dram_addr_out[ROW_BITS-1:0] = row;  // Row zero-extended
        end else begin
            act_n_out = 1'b1;
            dram_addr_out[RAS_BIT]      = ras;
            dram_addr_out[CAS_BIT]      = cas;
            dram_addr_out[WE_BIT]       = we;
            dram_addr_out[COL_BITS-1:0] = col;  // Column in the low bits
        end
    end

endmodule : dram_cmd_encoder

/* dram_timer.sv */
// Latency down-counter for DRAM waits; loaded by the controller FSM, flags expiry with timer_done
module dram_timer #(
    parameter int TIMER_BITS = 5
) (
    input  logic                  clk_in,
    input  logic                  rst_N_in,
    input  logic                  timer_load,   // One-cycle pulse on the command edge
    input  logic [TIMER_BITS-1:0] timer_count,  // Cycles until done
    output logic                  timer_done
);

    logic [TIMER_BITS-1:0] count;

    // Count down, park at zero
    always_ff @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            count <= '0;
        end else if (timer_load) begin
            count <= timer_count;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Rises timer_count cycles after the load edge
    assign timer_done = (count == '0) && !timer_load;

endmodule : dram_timer

/* llc_ctrl_fsm.sv */
// Request sequencer for the LLC: lookup, DRAM row/column commands, line fill and the response
module llc_ctrl_fsm
    import llc_pkg::*;
#(
    parameter int INDEX_BITS  = 6,
    parameter int ACT_LATENCY = 8,   // ACTIVATE to column command
    parameter int CAS_LATENCY = 22,  // READ to data, WRITE to PRECHARGE
    parameter int PRE_LATENCY = 5,   // PRECHARGE to row closed
    parameter int TIMER_BITS  = 5
) (
    input  logic                  clk_in,
    input  logic                  rst_N_in,
    // Higher-level cache request
    input  logic                  hc_valid_in,
    input  logic                  hc_ready_in,
    input  logic [PADDR_BITS-1:0] hc_addr_in,
    input  logic [DATA_BITS-1:0]  hc_value_in,
    input  logic                  hc_we_in,
    // Higher-level cache response
    output logic                  hc_ready_out,
    output logic                  hc_valid_out,
    output logic [PADDR_BITS-1:0] hc_addr_out,
    output logic [DATA_BITS-1:0]  hc_value_out,
    // DIMM data
    input  logic [DATA_BITS-1:0]  dq_rdata_in,
    output logic [DATA_BITS-1:0]  dq_wdata_out,
    // Command encoder
    output dram_cmd_t             dram_cmd,
    output logic [PADDR_BITS-1:0] req_addr,
    // Latency timer
    output logic                  timer_load,
    output logic [TIMER_BITS-1:0] timer_count,
    input  logic                  timer_done,
    // Line store
    output logic [PADDR_BITS-1:0] lookup_addr,
    output logic                  store_we,
    output logic [DATA_BITS-1:0]  store_data,
    input  logic                  hit,
    input  logic [DATA_BITS-1:0]  line_data
);

    // A wait state leaves on the edge LATENCY cycles after its command edge
    localparam logic [TIMER_BITS-1:0] ACT_COUNT = TIMER_BITS'(ACT_LATENCY - 1);
    localparam logic [TIMER_BITS-1:0] CAS_COUNT = TIMER_BITS'(CAS_LATENCY - 1);
    localparam logic [TIMER_BITS-1:0] PRE_COUNT = TIMER_BITS'(PRE_LATENCY - 1);
    localparam int                    MAX_WAIT  = 1 << TIMER_BITS;

    // Elaboration checks on the parameter set
    if (INDEX_BITS < 1 || INDEX_BITS >= PADDR_BITS) begin : g_bad_index
        $error("INDEX_BITS must leave at least one tag bit");
    end
    if (ACT_LATENCY > MAX_WAIT || CAS_LATENCY > MAX_WAIT || PRE_LATENCY > MAX_WAIT) begin : g_bad_timer
        $error("TIMER_BITS too narrow for the DRAM latencies");
    end

    llc_state_t            state;
    llc_state_t            next_state;
    logic [PADDR_BITS-1:0] req_addr_q;    // Captured request
    logic [DATA_BITS-1:0]  req_value_q;
    logic                  req_we_q;
    logic [DATA_BITS-1:0]  resp_value_q;  // Read word, or the written word
    logic                  accept;
    logic                  fill;

    assign accept = (state == IDLE) && hc_valid_in;
    assign fill   = (state == READ_WAIT) && timer_done;  // DRAM word stable this edge

    // ------------------------------------------------
    // State and request registers
    // ------------------------------------------------
    always_ff @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            state    <= IDLE;
            req_we_q <= 1'b0;
        end else begin
            state <= next_state;
            if (accept) begin
                req_we_q <= hc_we_in;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (accept) begin
            req_addr_q  <= hc_addr_in;
            req_value_q <= hc_value_in;
        end
        if (state == CHECK_HIT) begin
            resp_value_q <= req_we_q ? req_value_q : line_data;  // Hit word or write echo
        end else if (fill) begin
            resp_value_q <= dq_rdata_in;  // Miss word straight from the DIMM
        end
    end

    // ------------------------------------------------
    // Next state
    // ------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            IDLE:       if (hc_valid_in) next_state = CHECK_HIT;
            CHECK_HIT:  next_state = (hit && !req_we_q) ? RESPOND : ROW_OPEN;
            ROW_OPEN:   next_state = ROW_WAIT;
            ROW_WAIT:   if (timer_done) next_state = req_we_q ? COL_WRITE : COL_READ;
            COL_READ:   next_state = READ_WAIT;
            READ_WAIT:  if (timer_done) next_state = CLOSE_ROW;
            COL_WRITE:  next_state = WRITE_WAIT;
            WRITE_WAIT: if (timer_done) next_state = CLOSE_ROW;
            CLOSE_ROW:  next_state = CLOSE_WAIT;
            CLOSE_WAIT: if (timer_done) next_state = RESPOND;
            RESPOND:    if (hc_ready_in) next_state = IDLE;  // Held under back-pressure
            default:    next_state = IDLE;
        endcase
    end

    // Command states issue for one cycle and arm the timer
    always_comb begin
        dram_cmd    = NOP;
        timer_load  = 1'b0;
        timer_count = '0;
        case (state)
            ROW_OPEN: begin
                dram_cmd    = ACTIVATE;
                timer_load  = 1'b1;
                timer_count = ACT_COUNT;
            end
            COL_READ: begin
                dram_cmd    = READ;
                timer_load  = 1'b1;
                timer_count = CAS_COUNT;
            end
            COL_WRITE: begin
                dram_cmd    = WRITE;
                timer_load  = 1'b1;
                timer_count = CAS_COUNT;  // Write data drains before PRECHARGE
            end
            CLOSE_ROW: begin
                dram_cmd    = PRECHARGE;
                timer_load  = 1'b1;
                timer_count = PRE_COUNT;
            end
            default: dram_cmd = NOP;
        endcase
    end

    // ------------------------------------------------
    // Outputs
    // ------------------------------------------------
    assign hc_ready_out = (state == IDLE);
    assign hc_valid_out = (state == RESPOND);
    assign hc_addr_out  = req_addr_q;
    assign hc_value_out = resp_value_q;
    assign req_addr     = req_addr_q;
    assign lookup_addr  = req_addr_q;
    assign dq_wdata_out = req_value_q;  // Sampled with WRITE

    // Fill on a read miss, update on a write hit, no allocate on a write miss
    assign store_we   = fill || ((state == COL_WRITE) && hit);
    assign store_data = fill ? dq_rdata_in : req_value_q;

endmodule : llc_ctrl_fsm

/* llc_top.sv */
// Top level of the write-through LLC with direct DIMM command drive; instances and wiring only
module llc_top
    import llc_pkg::*;
#(
    parameter int INDEX_BITS  = 6,   // 64 lines
    parameter int ACT_LATENCY = 8,
    parameter int CAS_LATENCY = 22,
    parameter int PRE_LATENCY = 5,
    parameter int TIMER_BITS  = 5
) (
    input  logic                      clk_in,
    input  logic                      rst_N_in,
    // Higher-level cache
    input  logic                      hc_valid_in,
    input  logic                      hc_ready_in,
    input  logic [PADDR_BITS-1:0]     hc_addr_in,
    input  logic [DATA_BITS-1:0]      hc_value_in,
    input  logic                      hc_we_in,
    output logic                      hc_ready_out,
    output logic                      hc_valid_out,
    output logic [PADDR_BITS-1:0]     hc_addr_out,
    output logic [DATA_BITS-1:0]      hc_value_out,
    // DIMM
    output logic                      cs_n_out,
    output logic                      act_n_out,
    output logic [DRAM_ADDR_BITS-1:0] dram_addr_out,
    output logic [BG_BITS-1:0]        bg_out,
    output logic [BA_BITS-1:0]        ba_out,
    output logic [DATA_BITS-1:0]      dq_wdata_out,
    input  logic [DATA_BITS-1:0]      dq_rdata_in
);

    // ------------------------------------------------
    // Internal nets
    // ------------------------------------------------
    dram_cmd_t             dram_cmd;
    logic [PADDR_BITS-1:0] req_addr;
    logic                  timer_load;
    logic [TIMER_BITS-1:0] timer_count;
    logic                  timer_done;
    logic [PADDR_BITS-1:0] lookup_addr;
    logic                  store_we;
    logic [DATA_BITS-1:0]  store_data;
    logic                  hit;
    logic [DATA_BITS-1:0]  line_data;

    llc_ctrl_fsm #(
        .INDEX_BITS (INDEX_BITS),
        .ACT_LATENCY(ACT_LATENCY),
        .CAS_LATENCY(CAS_LATENCY),
        .PRE_LATENCY(PRE_LATENCY),
        .TIMER_BITS (TIMER_BITS)
    ) i_ctrl_fsm (
        .clk_in      (clk_in),
        .rst_N_in    (rst_N_in),
        .hc_valid_in (hc_valid_in),
        .hc_ready_in (hc_ready_in),
        .hc_addr_in  (hc_addr_in),
        .hc_value_in (hc_value_in),
        .hc_we_in    (hc_we_in),
        .hc_ready_out(hc_ready_out),
        .hc_valid_out(hc_valid_out),
        .hc_addr_out (hc_addr_out),
        .hc_value_out(hc_value_out),
        .dq_rdata_in (dq_rdata_in),
        .dq_wdata_out(dq_wdata_out),
        .dram_cmd    (dram_cmd),
        .req_addr    (req_addr),
        .timer_load  (timer_load),
        .timer_count (timer_count),
        .timer_done  (timer_done),
        .lookup_addr (lookup_addr),
        .store_we    (store_we),
        .store_data  (store_data),
        .hit         (hit),
        .line_data   (line_data)
    );

    // Wait counter for all DRAM latencies
    dram_timer #(
        .TIMER_BITS(TIMER_BITS)
    ) i_timer (
        .clk_in     (clk_in),
        .rst_N_in   (rst_N_in),
        .timer_load (timer_load),
        .timer_count(timer_count),
        .timer_done (timer_done)
    );

    llc_line_store #(
        .INDEX_BITS(INDEX_BITS)
    ) i_line_store (
        .clk_in     (clk_in),
        .rst_N_in   (rst_N_in),
        .lookup_addr(lookup_addr),
        .store_we   (store_we),
        .store_data (store_data),
        .hit        (hit),
        .line_data  (line_data)
    );

    // Pin encoding, purely combinational
    dram_cmd_encoder i_cmd_encoder (
        .dram_cmd     (dram_cmd),
        .req_addr     (req_addr),
        .cs_n_out     (cs_n_out),
        .act_n_out    (act_n_out),
        .dram_addr_out(dram_addr_out),
        .bg_out       (bg_out),
        .ba_out       (ba_out)
    );

endmodule : llc_top

/* llc_top_sva.sv */
// Assertion checker bound to llc_top for the response hold, quiet DIMM pins and READ spacing
module llc_top_sva
    import llc_pkg::*;
#(
    parameter int CAS_LATENCY = 22
) (
    input logic                      clk_in,
    input logic                      rst_N_in,
    input logic                      hc_valid_out,
    input logic                      hc_ready_in,
    input logic                      hc_ready_out,
    input logic                      cs_n_out,
    input logic                      act_n_out,
    input logic [DRAM_ADDR_BITS-1:0] dram_addr_out
);

    int   since_read;      // Saturating count of edges since the last READ
    int   fail_count = 0;  // Assertion failures so far
    logic read_cmd;

    assign read_cmd = !cs_n_out && act_n_out && (dram_addr_out[RAS_BIT -: 3] == 3'b101);

    always @(posedge clk_in or negedge rst_N_in) begin
        if (!rst_N_in) begin
            since_read <= CAS_LATENCY;
        end else if (read_cmd) begin
            since_read <= 0;
        end else if (since_read < CAS_LATENCY) begin
            since_read <= since_read + 1;
        end
    end

    // ------------------------------------------------
    // Properties
    // ------------------------------------------------
    a_valid_held: assert property (@(posedge clk_in) disable iff (!rst_N_in)
        hc_valid_out && !hc_ready_in |=> hc_valid_out)
    else begin
        $error("response dropped before hc_ready_in was high");
        fail_count++;
    end

    // DIMM stays deselected while waiting for a request or holding a response
    a_no_cmd_outside_req: assert property (@(posedge clk_in) disable iff (!rst_N_in)
        hc_ready_out || hc_valid_out |-> cs_n_out)
    else begin
        $error("DRAM command while idle or responding");
        fail_count++;
    end

    a_read_spacing: assert property (@(posedge clk_in) disable iff (!rst_N_in)
        !cs_n_out |-> since_read >= CAS_LATENCY)
    else begin
        $error("DRAM command within CAS latency of a READ");
        fail_count++;
    end

endmodule : llc_top_sva

bind llc_top llc_top_sva #(
    .CAS_LATENCY(CAS_LATENCY)
) i_llc_top_sva (
    .clk_in       (clk_in),
    .rst_N_in     (rst_N_in),
    .hc_valid_out (hc_valid_out),
    .hc_ready_in  (hc_ready_in),
    .hc_ready_out (hc_ready_out),
    .cs_n_out     (cs_n_out),
    .act_n_out    (act_n_out),
    .dram_addr_out(dram_addr_out)
);

/* tb_llc_top.sv */
// Testbench top for llc_top that runs directed and random requests against a DIMM model
module tb_llc_top
    import llc_pkg::*;
();

    localparam int INDEX_BITS = 6;
    localparam int ACT_LAT    = 8;
    localparam int CAS_LAT    = 22;
    localparam int PRE_LAT    = 5;
    localparam int MAX_STALL  = 6;   // Longest back-pressure stretch
    localparam int N_RAND     = 24;
    localparam int N_REQ      = 8 + N_RAND;
    localparam int TIMEOUT    = 20 + N_REQ * (ACT_LAT + CAS_LAT + PRE_LAT + MAX_STALL + 12);
    localparam logic [31:0] SEED = 32'h69d47f12;

    logic clk_in = 1'b0;
    logic rst_N_in, hc_valid_in, hc_ready_in, hc_we_in, cs_n_out, act_n_out;
    logic hc_ready_out, hc_valid_out;
    logic [PADDR_BITS-1:0]     hc_addr_in, hc_addr_out;
    logic [DATA_BITS-1:0]      hc_value_in, hc_value_out, dq_wdata_out, dq_rdata_in;
    logic [DRAM_ADDR_BITS-1:0] dram_addr_out;
    logic [BG_BITS-1:0]        bg_out;
    logic [BA_BITS-1:0]        ba_out;

    // Outstanding request and its expected response
    string                 name_q[$];
    logic [PADDR_BITS-1:0] addr_q[$];
    logic [DATA_BITS-1:0]  word_q[$];
    logic [2:0]            cmd_q[$];  // {ACTIVATE, READ, WRITE}; PRECHARGE pairs with ACTIVATE

    // DIMM model and reference state
    logic [DATA_BITS-1:0] dimm_mem [1 << PADDR_BITS];
    logic [DATA_BITS-1:0] shadow   [1 << PADDR_BITS];
    logic [ROW_BITS-1:0]  open_row [1 << (BG_BITS + BA_BITS)];
    logic [15:0]          row_open = '0;
    logic [DATA_BITS-1:0] rd_word = '0;
    logic [PADDR_BITS-INDEX_BITS-1:0] tag_m [1 << INDEX_BITS];
    logic [(1 << INDEX_BITS)-1:0]     tag_ok;
    int rd_count = 0, n_act = 0, n_rd = 0, n_wr = 0, n_pre = 0, model_errors = 0;
    int seen_act = 0, seen_rd = 0, seen_wr = 0, seen_pre = 0, seen_err = 0;
    int n_pass = 0, n_fail = 0, reset_bad = 0, cycle_count = 0;
    bit cur_bad = 1'b0;

    always #10 clk_in = ~clk_in;  // Period 20

    llc_top #(
        .INDEX_BITS (INDEX_BITS),
        .ACT_LATENCY(ACT_LAT),
        .CAS_LATENCY(CAS_LAT),
        .PRE_LATENCY(PRE_LAT),
        .TIMER_BITS (5)
    ) i_llc_top (.*);

    // Initial DRAM contents built from every address bit
    function automatic logic [DATA_BITS-1:0] fill_pattern(input logic [PADDR_BITS-1:0] a);
        return {a ^ 16'hc3a5, ~a, {a[7:0], a[15:8]}, a + 16'h1357};
    endfunction

    function automatic bit model_hit(input logic [PADDR_BITS-1:0] a);
        return tag_ok[a[INDEX_BITS-1:0]] &&
               (tag_m[a[INDEX_BITS-1:0]] == a[PADDR_BITS-1:INDEX_BITS]);
    endfunction

    // Expected response word; a write echoes its own data
    function automatic logic [DATA_BITS-1:0] expected_word(input logic we,
                                                           input logic [PADDR_BITS-1:0] a,
                                                           input logic [DATA_BITS-1:0] v);
        return we ? v : shadow[a];
    endfunction

    function automatic string cmd_counts(input int a, input int r, input int w, input int p);
        return $sformatf("%0d/%0d/%0d/%0d", a, r, w, p);
    endfunction

    task automatic check_field(input string what, input int expv, input int actv);
        if (expv != actv) begin
            $display("mismatch %s %s expected %h actual %h", name_q[0], what, expv, actv);
            model_errors++;
        end
    endtask

    // ------------------------------------------------
    // DIMM model
    // ------------------------------------------------
    always @(posedge clk_in) begin
        int                    bank;
        logic [PADDR_BITS-1:0] full;
        bank = {bg_out, ba_out};
        full = {open_row[bank], bg_out, ba_out, dram_addr_out[COL_BITS-1:0]};  // Row on top
        if (rd_count != 0) rd_count <= rd_count - 1;
        if (rst_N_in && !cs_n_out && name_q.size() == 0) begin
            $display("DRAM command issued with no request outstanding");
            model_errors++;
        end else if (rst_N_in && !cs_n_out) begin
            if (!act_n_out) begin  // ACTIVATE with the row zero-extended
                check_field("activate row", addr_q[0][ROW_LSB +: ROW_BITS], dram_addr_out);
                check_field("activate bank", addr_q[0][BA_LSB +: BG_BITS + BA_BITS], bank);
                open_row[bank] <= dram_addr_out[ROW_BITS-1:0];
                row_open[bank] <= 1'b1;
                n_act <= n_act + 1;
            end else if (!row_open[bank]) begin
                $display("%s: column command or PRECHARGE to a closed bank", name_q[0]);
                model_errors++;
            end else begin
                case (dram_addr_out[RAS_BIT -: 3])
                    3'b101: begin  // READ with data due CAS_LAT edges on
                        check_field("read address", addr_q[0], full);
                        rd_word  <= dimm_mem[full];
                        rd_count <= CAS_LAT;
                        n_rd     <= n_rd + 1;
                    end
                    3'b100: begin  // WRITE
                        check_field("write address", addr_q[0], full);
                        dimm_mem[full] <= dq_wdata_out;
                        n_wr           <= n_wr + 1;
                    end
                    3'b010: begin  // PRECHARGE
                        row_open[bank] <= 1'b0;
                        n_pre          <= n_pre + 1;
                    end
                    default: begin
                        $display("%s: unknown command on the DIMM pins", name_q[0]);
                        model_errors++;
                    end
                endcase
            end
        end
    end

    // Read data valid only around its capture edge
    always @(negedge clk_in) dq_rdata_in = (rd_count == 1) ? rd_word : ~rd_word;

    // ------------------------------------------------
    // Response compare
    // ------------------------------------------------
    always @(posedge clk_in) begin
        if (rst_N_in && hc_valid_out && name_q.size() == 0) begin
            $display("response seen with no request outstanding");
            n_fail++;
        end else if (rst_N_in && hc_valid_out) begin
            if (hc_addr_out !== addr_q[0]) begin  // Checked every held cycle
                $display("mismatch %s address expected %h actual %h",
                         name_q[0], addr_q[0], hc_addr_out);
                cur_bad = 1'b1;
            end
            if (hc_value_out !== word_q[0]) begin
                $display("mismatch %s value expected %h actual %h",
                         name_q[0], word_q[0], hc_value_out);
                cur_bad = 1'b1;
            end
            if (hc_ready_in) begin
                if (n_act - seen_act != cmd_q[0][2] || n_pre - seen_pre != cmd_q[0][2] ||
                    n_rd - seen_rd != cmd_q[0][1] || n_wr - seen_wr != cmd_q[0][0]) begin
                    $display("mismatch %s act/rd/wr/pre expected %s actual %s", name_q[0],
                             cmd_counts(cmd_q[0][2], cmd_q[0][1], cmd_q[0][0], cmd_q[0][2]),
                             cmd_counts(n_act - seen_act, n_rd - seen_rd,
                                        n_wr - seen_wr, n_pre - seen_pre));
                    cur_bad = 1'b1;
                end
                if (cmd_q[0][0] && dimm_mem[addr_q[0]] !== word_q[0]) begin  // Write-through
                    $display("mismatch %s dram word expected %h actual %h",
                             name_q[0], word_q[0], dimm_mem[addr_q[0]]);
                    cur_bad = 1'b1;
                end
                if (model_errors != seen_err) cur_bad = 1'b1;
                $display("test %s %s", name_q[0], cur_bad ? "FAIL" : "ok");
                if (cur_bad) n_fail++;
                else n_pass++;
                void'(name_q.pop_front());
                void'(addr_q.pop_front());
                void'(word_q.pop_front());
                void'(cmd_q.pop_front());
                seen_act = n_act;
                seen_rd  = n_rd;
                seen_wr  = n_wr;
                seen_pre = n_pre;
                seen_err = model_errors;
                cur_bad  = 1'b0;
            end
        end
    end

    always @(posedge clk_in) begin
        cycle_count++;
        if (cycle_count > TIMEOUT) begin
            $display("timeout after %0d cycles, a response never arrived", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    // ------------------------------------------------
    // Stimulus
    // ------------------------------------------------
    task automatic do_request(input string name, input logic we, input logic [PADDR_BITS-1:0] a,
                              input logic [DATA_BITS-1:0] v, input int stall);
        bit hit_p;
        hit_p = model_hit(a);
        name_q.push_back(name);
        addr_q.push_back(a);
        word_q.push_back(expected_word(we, a, v));
        cmd_q.push_back({we || !hit_p, !we && !hit_p, we});
        if (we) shadow[a] = v;
        if (!we && !hit_p) begin  // Read miss fills but write miss does not allocate
            tag_m[a[INDEX_BITS-1:0]]  = a[PADDR_BITS-1:INDEX_BITS];
            tag_ok[a[INDEX_BITS-1:0]] = 1'b1;
        end
        while (!hc_ready_out) @(negedge clk_in);
        {hc_valid_in, hc_we_in, hc_addr_in, hc_value_in} = {1'b1, we, a, v};
        @(negedge clk_in);
        {hc_valid_in, hc_addr_in, hc_value_in} = {1'b0, ~a, ~v};  // Must be captured by now
        while (!hc_valid_out) @(negedge clk_in);
        repeat (stall) @(negedge clk_in);
        hc_ready_in = 1'b1;
        @(negedge clk_in);
        hc_ready_in = 1'b0;
    endtask

    initial begin
        logic [PADDR_BITS-1:0] addr;
        int                    total_bad;
        void'($urandom(SEED));
        for (int i = 0; i < (1 << PADDR_BITS); i++) begin
            dimm_mem[i] = fill_pattern(i);
            shadow[i]   = fill_pattern(i);
        end
        tag_ok = '0;
        {rst_N_in, hc_valid_in, hc_ready_in, hc_we_in} = 4'b0000;
        {hc_addr_in, hc_value_in, dq_rdata_in} = '0;
        repeat (8) @(negedge clk_in);
        rst_N_in = 1'b1;
        @(negedge clk_in);
        if (!hc_ready_out || hc_valid_out || !cs_n_out) begin
            $display("mismatch reset_state ready/valid/cs_n expected 101 actual %b%b%b",
                     hc_ready_out, hc_valid_out, cs_n_out);
            reset_bad = 1;
        end
        $display("test reset_state %s", reset_bad ? "FAIL" : "ok");
        do_request("read_miss", 1'b0, 16'h1234, '0, 0);
        do_request("read_hit", 1'b0, 16'h1234, '0, 2);
        do_request("read_alias", 1'b0, 16'h5634, '0, 0);  // Same index and another tag
        do_request("write_hit", 1'b1, 16'h5634, 64'h0123_4567_89ab_cdef, 0);
        do_request("read_after_whit", 1'b0, 16'h5634, '0, 3);
        do_request("write_miss", 1'b1, 16'h9abc, 64'hfeed_face_0bad_cafe, 0);
        do_request("read_after_wmiss", 1'b0, 16'h9abc, '0, 0);
        do_request("read_evicted", 1'b0, 16'h1234, '0, 1);
        for (int i = 0; i < N_RAND; i++) begin
            addr = 16'(($urandom % 4) * 16'h1040 + ($urandom % 8));  // Small pool for hits
            do_request($sformatf("random_%0d", i), ($urandom % 3) == 0, addr,
                       {$urandom, $urandom}, $urandom % (MAX_STALL + 1));
        end
        @(negedge clk_in);
        total_bad = n_fail + reset_bad + model_errors + i_llc_top.i_llc_top_sva.fail_count;
        $display("tests %0d, ok %0d, bad %0d, model errors %0d, assertion failures %0d",
                 n_pass + n_fail + 1, n_pass + 1 - reset_bad, n_fail + reset_bad,
                 model_errors, i_llc_top.i_llc_top_sva.fail_count);
        if (total_bad == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_llc_top

/* llc_top.f */
llc_pkg.sv
llc_line_store.sv
dram_cmd_encoder.sv
dram_timer.sv
llc_ctrl_fsm.sv
llc_top.sv
llc_top_sva.sv
tb_llc_top.sv
